//--- hw/decoder_pkg.sv
package decoder_pkg;

        ////////////////////////////////////////////////////////////
        // stream geometry
        ////////////////////////////////////////////////////////////
        localparam int SAMPLE_W         = 8;
        localparam int SAMPLES_PER_SLOT = 80;
        localparam int HALF_SLOT        = SAMPLES_PER_SLOT / 2;
        localparam int PRE_SLOTS        = 7;
        localparam int FRAME_SLOTS      = 119;
        localparam int DATA_SLOTS       = FRAME_SLOTS - PRE_SLOTS;
        localparam int CNT_W            = 7;

        // symbols and output word
        localparam int SYMBOL_W = 2;
        localparam int FRAME_W  = DATA_SLOTS * SYMBOL_W;
        localparam logic [SYMBOL_W-1:0] SYM_HIGH = 2'b10;
        localparam logic [SYMBOL_W-1:0] SYM_LOW  = 2'b01;

        // detection levels
        localparam int EDGE_DELTA = 50;
        localparam int THRESHOLD  = 50;
        localparam int ACC_W      = 16;

        ////////////////////////////////////////////////////////////
        // preamble check points
        ////////////////////////////////////////////////////////////
        localparam int PRE_CHECK_SLOT_0   = 1;
        localparam int PRE_CHECK_SLOT_1   = 3;
        localparam int PRE_CHECK_SLOT_2   = 4;
        localparam int PRE_CHECK_SAMPLE_0 = 0;
        localparam int PRE_CHECK_SAMPLE_1 = 40;
        localparam int PRE_CHECK_SAMPLE_2 = 40;
        localparam int PRE_TOL            = 1;

        // frame fsm encoding
        localparam int STATE_W = 2;
        localparam logic [STATE_W-1:0] ST_IDLE   = 2'b00;
        localparam logic [STATE_W-1:0] ST_PRE    = 2'b01;
        localparam logic [STATE_W-1:0] ST_DECODE = 2'b11;
        localparam logic [STATE_W-1:0] ST_DONE   = 2'b10;

        // split-slot template, positive half first
        function automatic logic template_pos(input logic [CNT_W-1:0] idx);
                return idx < CNT_W'(HALF_SLOT);
        endfunction

endpackage

//--- hw/slot_if.sv
`timescale 1ns/1ps

interface slot_if;

        // sample aligned with the slot counters
        logic [decoder_pkg::SAMPLE_W-1:0] sample;
        logic [decoder_pkg::CNT_W-1:0]    sample_idx;

        // data slot timing
        logic                             data_slot;
        logic                             slot_end;
        logic                             frame_start;

        modport ctrl (
                output sample,
                output sample_idx,
                output data_slot,
                output slot_end,
                output frame_start
        );

        modport data (
                input  sample,
                input  sample_idx,
                input  data_slot,
                input  slot_end,
                input  frame_start
        );

endinterface

//--- hw/edge_detect.sv
`timescale 1ns/1ps

module edge_detect (
        input  logic                             clk,
        input  logic                             rst_n,
        input  logic [decoder_pkg::SAMPLE_W-1:0] data_in,
        output logic [decoder_pkg::SAMPLE_W-1:0] sample,
        output logic                             rise
);

        // one extra bit so the difference keeps its sign
        logic signed [decoder_pkg::SAMPLE_W:0] diff;

        ////////////////////////////////////////////////////////////
        // jump between the incoming and the held sample
        ////////////////////////////////////////////////////////////
        assign diff = $signed({1'b0, data_in}) - $signed({1'b0, sample});

        // sample and flag leave together, one cycle after the input
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        sample <= '0;
                        rise   <= 1'b0;
                end else begin
                        sample <= data_in;
                        rise   <= diff > decoder_pkg::EDGE_DELTA;
                end
        end

endmodule

//--- hw/frame_ctrl.sv
`timescale 1ns/1ps

module frame_ctrl (
        input  logic                             clk,
        input  logic                             rst_n,
        input  logic                             en,
        input  logic [decoder_pkg::SAMPLE_W-1:0] sample,
        input  logic                             rise,
        slot_if.ctrl                             slot
);

        localparam int CNT_W   = decoder_pkg::CNT_W;
        localparam int SPS     = decoder_pkg::SAMPLES_PER_SLOT;
        localparam int POS_W   = $clog2(decoder_pkg::FRAME_SLOTS * SPS);
        localparam int N_CHECK = 3;

        // check points as sample offsets from the frame start
        localparam int CHECK_POS [N_CHECK] = '{
                decoder_pkg::PRE_CHECK_SLOT_0 * SPS + decoder_pkg::PRE_CHECK_SAMPLE_0,
                decoder_pkg::PRE_CHECK_SLOT_1 * SPS + decoder_pkg::PRE_CHECK_SAMPLE_1,
                decoder_pkg::PRE_CHECK_SLOT_2 * SPS + decoder_pkg::PRE_CHECK_SAMPLE_2
        };

        logic [decoder_pkg::STATE_W-1:0] state;
        logic [decoder_pkg::STATE_W-1:0] state_nxt;
        logic [CNT_W-1:0]                sample_cnt;
        logic [CNT_W-1:0]                slot_cnt;
        logic [POS_W-1:0]                pos;
        logic [N_CHECK-1:0]              seen;
        logic [N_CHECK-1:0]              hit;
        logic                            miss;
        logic                            start;
        logic                            slot_last;

        assign start     = (state == decoder_pkg::ST_IDLE) && en && rise;
        assign slot_last = (sample_cnt == CNT_W'(SPS - 1));
        assign pos       = POS_W'(slot_cnt) * POS_W'(SPS) + POS_W'(sample_cnt);

        ////////////////////////////////////////////////////////////
        // preamble windows
        ////////////////////////////////////////////////////////////
        always_comb begin
                hit  = '0;
                miss = 1'b0;
                for (int k = 0; k < N_CHECK; k++) begin
                        if (pos >= POS_W'(CHECK_POS[k] - decoder_pkg::PRE_TOL) &&
                            pos <= POS_W'(CHECK_POS[k] + decoder_pkg::PRE_TOL)) begin
                                hit[k] = rise;
                        end
                        // last cycle of the window and still nothing
                        if (pos == POS_W'(CHECK_POS[k] + decoder_pkg::PRE_TOL) &&
                            !(seen[k] || hit[k])) begin
                                miss = 1'b1;
                        end
                end
        end

        ////////////////////////////////////////////////////////////
        // state machine
        ////////////////////////////////////////////////////////////
        always_comb begin
                state_nxt = state;
                case (state)
                        decoder_pkg::ST_IDLE: begin
                                if (start) begin
                                        state_nxt = decoder_pkg::ST_PRE;
                                end
                        end
                        decoder_pkg::ST_PRE: begin
                                if (miss) begin
                                        state_nxt = decoder_pkg::ST_IDLE;
                                end else if (slot_last &&
                                             slot_cnt == CNT_W'(decoder_pkg::PRE_SLOTS - 1)) begin
                                        state_nxt = decoder_pkg::ST_DECODE;
                                end
                        end
                        decoder_pkg::ST_DECODE: begin
                                if (slot_last &&
                                    slot_cnt == CNT_W'(decoder_pkg::FRAME_SLOTS - 1)) begin
                                        state_nxt = decoder_pkg::ST_DONE;
                                end
                        end
                        default: begin
                                state_nxt = decoder_pkg::ST_IDLE;
                        end
                endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= decoder_pkg::ST_IDLE;
                end else begin
                        state <= state_nxt;
                end
        end

        // counters run only inside a frame
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        sample_cnt <= '0;
                        slot_cnt   <= '0;
                        seen       <= '0;
                end else if (state == decoder_pkg::ST_PRE || state == decoder_pkg::ST_DECODE) begin
                        seen <= seen | hit;
                        if (slot_last) begin
                                sample_cnt <= '0;
                                slot_cnt   <= slot_cnt + CNT_W'(1);
                        end else begin
                                sample_cnt <= sample_cnt + CNT_W'(1);
                        end
                end else begin
                        // rising sample itself is slot 0 sample 0
                        sample_cnt <= start ? CNT_W'(1) : '0;
                        slot_cnt   <= '0;
                        seen       <= '0;
                end
        end

        ////////////////////////////////////////////////////////////
        // slot timing to the data path
        ////////////////////////////////////////////////////////////
        assign slot.sample      = sample;
        assign slot.sample_idx  = sample_cnt;
        assign slot.data_slot   = (state == decoder_pkg::ST_DECODE);
        assign slot.slot_end    = slot.data_slot && slot_last;
        assign slot.frame_start = slot.data_slot && (sample_cnt == '0) &&
                                  (slot_cnt == CNT_W'(decoder_pkg::PRE_SLOTS));

endmodule

//--- hw/slot_correlator.sv
`timescale 1ns/1ps

module slot_correlator (
        input  logic                             clk,
        input  logic                             rst_n,
        slot_if.data                             slot,
        output logic [decoder_pkg::SYMBOL_W-1:0] symbol,
        output logic                             symbol_stb
);

        localparam int ACC_W = decoder_pkg::ACC_W;

        logic signed [ACC_W-1:0] acc;
        logic signed [ACC_W-1:0] acc_base;
        logic signed [ACC_W-1:0] acc_nxt;
        logic signed [ACC_W-1:0] term;

        ////////////////////////////////////////////////////////////
        // template correlation
        ////////////////////////////////////////////////////////////
        assign term = $signed(ACC_W'(slot.sample));

        // restart at sample 0 of each slot
        assign acc_base = (slot.sample_idx == '0) ? '0 : acc;

        assign acc_nxt = decoder_pkg::template_pos(slot.sample_idx) ? acc_base + term
                                                                    : acc_base - term;

        always_ff @(posedge clk) begin
                if (slot.data_slot) begin
                        acc <= acc_nxt;
                end
        end

        ////////////////////////////////////////////////////////////
        // decision on the full slot sum
        ////////////////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (slot.slot_end) begin
                        symbol <= (acc_nxt > decoder_pkg::THRESHOLD) ? decoder_pkg::SYM_HIGH
                                                                      : decoder_pkg::SYM_LOW;
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        symbol_stb <= 1'b0;
                end else begin
                        symbol_stb <= slot.slot_end;
                end
        end

endmodule

//--- hw/frame_assembler.sv
`timescale 1ns/1ps

module frame_assembler (
        input  logic                             clk,
        input  logic                             rst_n,
        slot_if.data                             slot,
        input  logic [decoder_pkg::SYMBOL_W-1:0] symbol,
        input  logic                             symbol_stb,
        output logic [decoder_pkg::FRAME_W-1:0]  data_out,
        output logic                             valid_out
);

        localparam int CNT_W = decoder_pkg::CNT_W;

        logic [CNT_W-1:0]                   sym_idx;
        logic [decoder_pkg::FRAME_W-1:0]    word;
        logic [decoder_pkg::FRAME_W-1:0]    word_nxt;
        logic                               last_sym;

        assign last_sym = (sym_idx == CNT_W'(decoder_pkg::DATA_SLOTS - 1));

        // symbol k lands in bits 2k+1..2k
        always_comb begin
                word_nxt = word;
                word_nxt[sym_idx * decoder_pkg::SYMBOL_W +: decoder_pkg::SYMBOL_W] = symbol;
        end

        always_ff @(posedge clk) begin
                if (symbol_stb) begin
                        word <= word_nxt;
                end
        end

        ////////////////////////////////////////////////////////////
        // symbol index and frame output
        ////////////////////////////////////////////////////////////
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        sym_idx   <= '0;
                        data_out  <= '0;
                        valid_out <= 1'b0;
                end else begin
                        valid_out <= symbol_stb && last_sym;
                        if (slot.frame_start) begin
                                sym_idx <= '0;
                        end else if (symbol_stb) begin
                                sym_idx <= sym_idx + CNT_W'(1);
                        end
                        if (symbol_stb && last_sym) begin
                                data_out <= word_nxt;
                        end
                end
        end

endmodule

//--- hw/decoder_core.sv
`timescale 1ns/1ps

module decoder_core (
        input  logic                             clk,
        input  logic                             rst_n,
        input  logic                             en,
        input  logic [decoder_pkg::SAMPLE_W-1:0] data_in,
        output logic [decoder_pkg::FRAME_W-1:0]  data_out,
        output logic                             valid_out
);

        logic [decoder_pkg::SAMPLE_W-1:0] sample;
        logic                             rise;
        logic [decoder_pkg::SYMBOL_W-1:0] symbol;
        logic                             symbol_stb;

        slot_if slot_bus ();

        ////////////////////////////////////////////////////////////
        // edge detection and frame control
        ////////////////////////////////////////////////////////////
        edge_detect u_edge_detect (
                .clk     (clk),
                .rst_n   (rst_n),
                .data_in (data_in),
                .sample  (sample),
                .rise    (rise)
        );

        frame_ctrl u_frame_ctrl (
                .clk    (clk),
                .rst_n  (rst_n),
                .en     (en),
                .sample (sample),
                .rise   (rise),
                .slot   (slot_bus.ctrl)
        );

        ////////////////////////////////////////////////////////////
        // data path
        ////////////////////////////////////////////////////////////
        slot_correlator u_slot_correlator (
                .clk        (clk),
                .rst_n      (rst_n),
                .slot       (slot_bus.data),
                .symbol     (symbol),
                .symbol_stb (symbol_stb)
        );

        frame_assembler u_frame_assembler (
                .clk        (clk),
                .rst_n      (rst_n),
                .slot       (slot_bus.data),
                .symbol     (symbol),
                .symbol_stb (symbol_stb),
                .data_out   (data_out),
                .valid_out  (valid_out)
        );

endmodule

//--- test/tb_decoder_core.sv
`timescale 1ns/1ps

module tb_decoder_core;

        localparam int SAMPLE_W  = decoder_pkg::SAMPLE_W;
        localparam int FRAME_W   = decoder_pkg::FRAME_W;
        localparam int SYMBOL_W  = decoder_pkg::SYMBOL_W;
        localparam int SPS       = decoder_pkg::SAMPLES_PER_SLOT;
        localparam int FRAME_LEN = decoder_pkg::FRAME_SLOTS * SPS;

        // stimulus levels and pulse placement
        localparam int BASE_MIN  = 10;
        localparam int BASE_MAX  = 30;
        localparam int PEAK_MIN  = 200;
        localparam int PEAK_MAX  = 240;
        localparam int PULSE_LEN = 20;
        localparam int OFS_HIGH  = 10;
        localparam int OFS_LOW   = 50;
        localparam int GAP_MIN   = 100;
        localparam int GAP_MAX   = 140;
        localparam int WAIT_MAX  = 200;

        // eight frames with gaps, plus slack
        localparam int N_FRAMES       = 8;
        localparam int TIMEOUT_CYCLES = (N_FRAMES + 2) * (FRAME_LEN + GAP_MAX);

        logic                    clk;
        logic                    rst_n;
        logic                    en;
        logic [SAMPLE_W-1:0]     data_in;
        logic [FRAME_W-1:0]      data_out;
        logic                    valid_out;

        logic [SAMPLE_W-1:0]     frame_buf [FRAME_LEN];
        logic [FRAME_W-1:0]      got_q [$];
        int                      cycle_cnt;

        decoder_core dut0 (
                .clk       (clk),
                .rst_n     (rst_n),
                .en        (en),
                .data_in   (data_in),
                .data_out  (data_out),
                .valid_out (valid_out)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #10 clk = ~clk;
                end
        end

        initial begin
                cycle_cnt = 0;
                while (cycle_cnt < TIMEOUT_CYCLES) begin
                        @(posedge clk);
                        cycle_cnt++;
                end
                $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
                abort_run();
        end

        // capture every decoded word
        always @(negedge clk) begin
                if (valid_out === 1'b1) begin
                        got_q.push_back(data_out);
                end
        end

        ////////////////////////////////////////////////////////////
        // checks
        ////////////////////////////////////////////////////////////
        task automatic abort_run();
                $display("Finished with errors");
                $fatal(1);
        endtask

        task automatic check_word(input string name, input logic [FRAME_W-1:0] expected,
                                  input logic [FRAME_W-1:0] actual);
                if (actual !== expected) begin
                        $display("[ERROR] %0t: %s expected %h, got %h",
                                 $time, name, expected, actual);
                        abort_run();
                end
        endtask

        task automatic check_valid(input string name, input logic expected, input logic actual);
                if (actual !== expected) begin
                        $display("[ERROR] %0t: %s expected %b, got %b",
                                 $time, name, expected, actual);
                        abort_run();
                end
        endtask

        ////////////////////////////////////////////////////////////
        // frame generator
        ////////////////////////////////////////////////////////////
        task automatic drive_sample(input logic [SAMPLE_W-1:0] value);
                @(negedge clk);
                data_in = value;
        endtask

        task automatic set_enable(input logic value);
                @(negedge clk);
                en = value;
        endtask

        task automatic add_pulse(input int start, input bit noisy);
                int amp;
                amp = $urandom_range(PEAK_MAX, PEAK_MIN);
                for (int j = 0; j < PULSE_LEN; j++) begin
                        if (noisy) begin
                                amp = $urandom_range(PEAK_MAX, PEAK_MIN);
                        end
                        frame_buf[start + j] = SAMPLE_W'(amp);
                end
        endtask

        task automatic build_frame(input bit noisy, input bit drop_slot3, input bit alternate);
                int  base;
                int  slot;
                bit  high;
                base = $urandom_range(BASE_MAX, BASE_MIN);
                for (int i = 0; i < FRAME_LEN; i++) begin
                        frame_buf[i] = noisy ? SAMPLE_W'($urandom_range(BASE_MAX, BASE_MIN))
                                             : SAMPLE_W'(base);
                end
                // start pulse, then the three preamble check points
                add_pulse(0, noisy);
                add_pulse(decoder_pkg::PRE_CHECK_SLOT_0 * SPS + decoder_pkg::PRE_CHECK_SAMPLE_0,
                          noisy);
                if (!drop_slot3) begin
                        add_pulse(decoder_pkg::PRE_CHECK_SLOT_1 * SPS +
                                  decoder_pkg::PRE_CHECK_SAMPLE_1, noisy);
                end
                add_pulse(decoder_pkg::PRE_CHECK_SLOT_2 * SPS + decoder_pkg::PRE_CHECK_SAMPLE_2,
                          noisy);
                // alternating halves keep stray restarts from passing the preamble
                for (int k = 0; k < decoder_pkg::DATA_SLOTS; k++) begin
                        slot = decoder_pkg::PRE_SLOTS + k;
                        high = alternate ? (k % 2 == 0) : 1'($urandom_range(1, 0));
                        add_pulse(slot * SPS + (high ? OFS_HIGH : OFS_LOW), noisy);
                end
        endtask

        task automatic send_frame(input bit noisy, input bit drop_slot3, input bit alternate);
                int gap;
                build_frame(noisy, drop_slot3, alternate);
                for (int i = 0; i < FRAME_LEN; i++) begin
                        drive_sample(frame_buf[i]);
                end
                gap = $urandom_range(GAP_MAX, GAP_MIN);
                repeat (gap) begin
                        drive_sample(SAMPLE_W'($urandom_range(BASE_MAX, BASE_MIN)));
                end
        endtask

        ////////////////////////////////////////////////////////////
        // reference model
        ////////////////////////////////////////////////////////////
        function automatic logic [FRAME_W-1:0] model_word();
                logic [FRAME_W-1:0] word;
                int                 sum;
                int                 first;
                word = '0;
                for (int k = 0; k < decoder_pkg::DATA_SLOTS; k++) begin
                        sum   = 0;
                        first = (decoder_pkg::PRE_SLOTS + k) * SPS;
                        for (int i = 0; i < SPS; i++) begin
                                if (i < decoder_pkg::HALF_SLOT) begin
                                        sum += int'(frame_buf[first + i]);
                                end else begin
                                        sum -= int'(frame_buf[first + i]);
                                end
                        end
                        word[k * SYMBOL_W +: SYMBOL_W] = (sum > decoder_pkg::THRESHOLD) ?
                                decoder_pkg::SYM_HIGH : decoder_pkg::SYM_LOW;
                end
                return word;
        endfunction

        task automatic expect_word();
                logic [FRAME_W-1:0] expected;
                int                 waited;
                expected = model_word();
                waited   = 0;
                while (got_q.size() == 0 && waited < WAIT_MAX) begin
                        @(negedge clk);
                        waited++;
                end
                if (got_q.size() == 0) begin
                        $display("no valid_out within %0d cycles after the frame", WAIT_MAX);
                        abort_run();
                end else if (got_q.size() > 1) begin
                        $display("valid_out rose more than once for a single frame");
                        abort_run();
                end else begin
                        check_word("data_out", expected, got_q.pop_front());
                end
        endtask

        task automatic expect_no_word();
                check_valid("valid_out", 1'b0, got_q.size() != 0);
        endtask

        ////////////////////////////////////////////////////////////
        // test sequence
        ////////////////////////////////////////////////////////////
        initial begin
                void'($urandom(32'h4b38_ef9a));
                rst_n    = 1'b0;
                en       = 1'b1;
                data_in  = SAMPLE_W'(BASE_MIN);
                repeat (4) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;

                // outputs idle after reset
                @(negedge clk);
                check_valid("valid_out", 1'b0, valid_out);
                check_word("data_out", '0, data_out);

                // three random frames back to back
                repeat (3) begin
                        send_frame(1'b0, 1'b0, 1'b0);
                        expect_word();
                end

                // noisy amplitudes and baseline
                send_frame(1'b1, 1'b0, 1'b0);
                expect_word();

                // missing slot 3 pulse, then a good frame
                send_frame(1'b0, 1'b1, 1'b1);
                expect_no_word();
                send_frame(1'b0, 1'b0, 1'b0);
                expect_word();

                // frame ignored while en is low
                set_enable(1'b0);
                send_frame(1'b0, 1'b0, 1'b0);
                expect_no_word();
                set_enable(1'b1);
                send_frame(1'b0, 1'b0, 1'b0);
                expect_word();

                $display("Finished with no errors");
                $finish;
        end

endmodule

//--- all.f
hw/decoder_pkg.sv
hw/slot_if.sv
hw/edge_detect.sv
hw/frame_ctrl.sv
hw/slot_correlator.sv
hw/frame_assembler.sv
hw/decoder_core.sv
test/tb_decoder_core.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the decoder testbench with verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --top-module tb_decoder_core -f all.f

# the simulator output goes to the log through tee
./obj_dir/Vtb_decoder_core | tee "$LOG"

if grep -qx "Finished with no errors" "$LOG"; then
        echo "simulation passed"
else
        echo "simulation failed, see $LOG"
        exit 1
fi
